//--- design/xr_settings.svh
// Size and identity settings for the XR memory block.
// Included by the package and by any module that needs a RAM width,
// the register count or the ID value.

`ifndef XR_SETTINGS_SVH
`define XR_SETTINGS_SVH

// palette RAM index width, one word per color entry
`define XR_COLOR_W      8

// main tile bank index width, plus the narrower second bank
`define XR_TILE_W       10
`define XR_TILE2_W      9

// copper program RAM index width
`define XR_COPP_W       9

// configuration register file
`define XR_NUM_REGS     8
`define XR_ID_VALUE     16'h5852

`endif

//--- design/xr_pkg.sv
// Shared types of the XR memory block: data words, addresses, palette
// colors and the request structs of the host, copper and register buses.
// Modules pull these in with a wildcard import in their header.

`include "xr_settings.svh"

package xr_pkg;

    typedef logic [15:0] word_t;
    typedef logic [15:0] addr_t;

    // palette index, video tile address (bank bit on top) and copper index
    typedef logic [`XR_COLOR_W-1:0] color_t;
    typedef logic [`XR_TILE_W:0]    tile_addr_t;
    typedef logic [`XR_COPP_W-1:0]  copp_addr_t;

    typedef struct packed {
        logic [3:0] alpha;
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
    } argb_t;

    // top two address bits pick the region
    typedef enum logic [1:0] {
        XR_REGION_REGS   = 2'b00,
        XR_REGION_TILE   = 2'b01,
        XR_REGION_COLOR  = 2'b10,
        XR_REGION_COPPER = 2'b11
    } xr_region_e;

    typedef struct packed {
        xr_region_e                  region;
        logic [13-`XR_COLOR_W-1:0]   unused;
        logic                        pal_b;
        color_t                      index;
    } xr_color_addr_t;

    typedef struct packed {
        xr_region_e                  region;
        logic [13-`XR_TILE_W-1:0]    unused;
        logic                        bank2;
        logic [`XR_TILE_W-1:0]       index;
    } xr_tile_addr_t;

    // one address word, seen raw or through a region view
    typedef union packed {
        addr_t          raw;
        xr_color_addr_t color;
        xr_tile_addr_t  tile;
    } xr_addr_u;

    typedef struct packed {
        logic  sel;
        logic  wr;
        addr_t addr;
        word_t data;
    } host_req_t;

    // copper only ever writes
    typedef struct packed {
        logic  sel;
        addr_t addr;
        word_t data;
    } copp_req_t;

    typedef struct packed {
        logic       wr;
        logic [6:0] addr;
        word_t      data;
    } xreg_bus_t;

endpackage

//--- design/xr_ram.sv
// Block RAM with one write port and one registered read port, both on clk.
// Used for the palettes, both tile banks and the copper program memory.
// Read data shows up one cycle after the read address.

`timescale 1ns/10ps
`default_nettype none

module xr_ram #(
    parameter int AWIDTH = 8,
    parameter int DWIDTH = 16
) (
    input  wire logic              clk,
    input  wire logic              wr_en_i,
    input  wire logic [AWIDTH-1:0] wr_addr_i,
    input  wire logic [DWIDTH-1:0] wr_data_i,
    input  wire logic [AWIDTH-1:0] rd_addr_i,
    output      logic [DWIDTH-1:0] rd_data_o
);

    logic [DWIDTH-1:0] mem [0:(1 << AWIDTH)-1];

    // read returns the old word when both ports hit the same address
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
        rd_data_o <= mem[rd_addr_i];
    end

endmodule

`default_nettype wire

//--- design/xr_regs.sv
// Configuration register file behind the XR register bus.
// Register 0 is a read-only ID, registers 1 and up are plain words.
// Writes land on the next edge, reads are combinational from the address.

`timescale 1ns/10ps
`default_nettype none

`include "xr_settings.svh"

module xr_regs import xr_pkg::*; (
    input  wire logic      clk,
    input  wire logic      rst_i,
    input  wire xreg_bus_t xreg_i,
    output      word_t     xreg_data_o
);

    word_t regs_q [1:`XR_NUM_REGS-1];
    logic  addr_valid;
    logic  addr_is_id;

    assign addr_is_id = (xreg_i.addr == 7'd0);
    assign addr_valid = (xreg_i.addr < 7'(`XR_NUM_REGS));

    // the ID slot silently drops writes
    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 1; i < `XR_NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (xreg_i.wr && addr_valid && !addr_is_id) begin
            regs_q[xreg_i.addr] <= xreg_i.data;
        end
    end

    // out of range addresses read back zero
    always_comb begin
        xreg_data_o = '0;
        if (addr_is_id) begin
            xreg_data_o = `XR_ID_VALUE;
        end else if (addr_valid) begin
            xreg_data_o = regs_q[xreg_i.addr];
        end
    end

endmodule

`default_nettype wire

//--- design/xr_mem_arb.sv
// Arbiter for the XR memories. Decodes host and copper requests, picks the
// writer (copper first), steers reads between the video ports and the host,
// and acks each accepted request one cycle later. Holds all five RAMs.
// Host reads of a RAM wait while the matching video select is high.

`timescale 1ns/10ps
`default_nettype none

`include "xr_settings.svh"

module xr_mem_arb import xr_pkg::*; (
    input  wire logic       clk,
    input  wire logic       rst_i,

    // host register port
    input  wire host_req_t  host_i,
    output      logic       host_ack_o,
    output      word_t      host_data_o,

    // copper write port
    input  wire copp_req_t  copp_i,
    output      logic       copp_ack_o,

    // register file bus
    output      xreg_bus_t  xreg_o,
    input  wire word_t      xreg_data_i,

    // video color lookup
    input  wire logic       vid_color_sel_i,
    input  wire color_t     vid_color_a_addr_i,
    input  wire color_t     vid_color_b_addr_i,
    output      argb_t      vid_color_a_o,
    output      argb_t      vid_color_b_o,

    // video tile fetch
    input  wire logic       vid_tile_sel_i,
    input  wire tile_addr_t vid_tile_addr_i,
    output      word_t      vid_tile_data_o,

    // copper program fetch
    input  wire logic       copp_prog_sel_i,
    input  wire copp_addr_t copp_prog_addr_i,
    output      word_t      copp_prog_data_o
);

    xr_addr_u   host_addr;
    xr_addr_u   copp_addr;
    xr_addr_u   wr_addr;
    word_t      wr_data;
    xr_region_e host_region;
    xr_region_e wr_region;

    logic       copp_accept;
    logic       host_free;
    logic       host_rd_block;
    logic       host_accept;
    logic       wr_en;

    logic       color_a_we;
    logic       color_b_we;
    logic       tile_we;
    logic       tile2_we;
    logic       copp_we;

    color_t     color_a_rd;
    color_t     color_b_rd;
    tile_addr_t tile_rd;
    copp_addr_t copp_rd;

    argb_t      color_a_q;
    argb_t      color_b_q;
    word_t      tile_q;
    word_t      tile2_q;
    word_t      copp_q;
    logic       tile_bank_q;
    word_t      regs_rd_q;

    assign host_addr.raw = host_i.addr;
    assign copp_addr.raw = copp_i.addr;
    assign host_region   = host_addr.color.region;

    // copper owns the write path whenever it selects
    assign wr_addr   = copp_i.sel ? copp_addr : host_addr;
    assign wr_data   = copp_i.sel ? copp_i.data : host_i.data;
    assign wr_region = wr_addr.color.region;

    assign copp_accept = copp_i.sel & ~copp_ack_o;
    assign host_free   = host_i.sel & ~host_ack_o & ~copp_i.sel;

    // video and copper fetch keep RAM read ports from host reads
    always_comb begin
        host_rd_block = 1'b0;
        if (!host_i.wr) begin
            case (host_region)
                XR_REGION_COLOR:  host_rd_block = vid_color_sel_i;
                XR_REGION_TILE:   host_rd_block = vid_tile_sel_i;
                XR_REGION_COPPER: host_rd_block = copp_prog_sel_i;
                default:          host_rd_block = 1'b0;
            endcase
        end
    end

    assign host_accept = host_free & ~host_rd_block;
    assign wr_en       = copp_accept | (host_accept & host_i.wr);

    // bank bits split palettes and tile banks
    assign color_a_we = wr_en & (wr_region == XR_REGION_COLOR) & ~wr_addr.color.pal_b;
    assign color_b_we = wr_en & (wr_region == XR_REGION_COLOR) & wr_addr.color.pal_b;
    assign tile_we    = wr_en & (wr_region == XR_REGION_TILE) & ~wr_addr.tile.bank2;
    assign tile2_we   = wr_en & (wr_region == XR_REGION_TILE) & wr_addr.tile.bank2;
    assign copp_we    = wr_en & (wr_region == XR_REGION_COPPER);

    // host register reads go out here too, copper is idle when they are accepted
    assign xreg_o.wr   = wr_en & (wr_region == XR_REGION_REGS);
    assign xreg_o.addr = wr_addr.raw[6:0];
    assign xreg_o.data = wr_data;

    // read address muxes, video side first
    assign color_a_rd = vid_color_sel_i ? vid_color_a_addr_i : host_addr.color.index;
    assign color_b_rd = vid_color_sel_i ? vid_color_b_addr_i : host_addr.color.index;
    assign tile_rd    = vid_tile_sel_i ? vid_tile_addr_i
                                       : {host_addr.tile.bank2, host_addr.tile.index};
    assign copp_rd    = copp_prog_sel_i ? copp_prog_addr_i : host_i.addr[`XR_COPP_W-1:0];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            host_ack_o <= 1'b0;
            copp_ack_o <= 1'b0;
        end else begin
            host_ack_o <= host_accept;
            copp_ack_o <= copp_accept;
        end
    end

    // bank of last cycle's tile read, and register data for the ack cycle
    always_ff @(posedge clk) begin
        tile_bank_q <= tile_rd[`XR_TILE_W];
        regs_rd_q   <= xreg_data_i;
    end

    assign vid_color_a_o    = color_a_q;
    assign vid_color_b_o    = color_b_q;
    assign vid_tile_data_o  = tile_bank_q ? tile2_q : tile_q;
    assign copp_prog_data_o = copp_q;

    // host read word, valid in the ack cycle while the address is still held
    always_comb begin
        host_data_o = regs_rd_q;
        case (host_region)
            XR_REGION_COLOR:  host_data_o = host_addr.color.pal_b ? word_t'(color_b_q)
                                                                  : word_t'(color_a_q);
            XR_REGION_TILE:   host_data_o = vid_tile_data_o;
            XR_REGION_COPPER: host_data_o = copp_q;
            default:          host_data_o = regs_rd_q;
        endcase
    end

    xr_ram #(.AWIDTH(`XR_COLOR_W), .DWIDTH(16)) u_color_a (
        .clk       (clk),
        .wr_en_i   (color_a_we),
        .wr_addr_i (wr_addr.color.index),
        .wr_data_i (wr_data),
        .rd_addr_i (color_a_rd),
        .rd_data_o (color_a_q)
    );

    xr_ram #(.AWIDTH(`XR_COLOR_W), .DWIDTH(16)) u_color_b (
        .clk       (clk),
        .wr_en_i   (color_b_we),
        .wr_addr_i (wr_addr.color.index),
        .wr_data_i (wr_data),
        .rd_addr_i (color_b_rd),
        .rd_data_o (color_b_q)
    );

    xr_ram #(.AWIDTH(`XR_TILE_W), .DWIDTH(16)) u_tile (
        .clk       (clk),
        .wr_en_i   (tile_we),
        .wr_addr_i (wr_addr.tile.index),
        .wr_data_i (wr_data),
        .rd_addr_i (tile_rd[`XR_TILE_W-1:0]),
        .rd_data_o (tile_q)
    );

    // second bank is smaller, upper index bits wrap
    xr_ram #(.AWIDTH(`XR_TILE2_W), .DWIDTH(16)) u_tile2 (
        .clk       (clk),
        .wr_en_i   (tile2_we),
        .wr_addr_i (wr_addr.tile.index[`XR_TILE2_W-1:0]),
        .wr_data_i (wr_data),
        .rd_addr_i (tile_rd[`XR_TILE2_W-1:0]),
        .rd_data_o (tile2_q)
    );

    xr_ram #(.AWIDTH(`XR_COPP_W), .DWIDTH(16)) u_copp (
        .clk       (clk),
        .wr_en_i   (copp_we),
        .wr_addr_i (wr_addr.raw[`XR_COPP_W-1:0]),
        .wr_data_i (wr_data),
        .rd_addr_i (copp_rd),
        .rd_data_o (copp_q)
    );

endmodule

`default_nettype wire

//--- design/xr_mem_top.sv
// Top of the XR memory block: the arbiter with its RAMs plus the
// configuration register file on the internal register bus.
// Host, copper and video ports pass straight through to the arbiter.

`timescale 1ns/10ps
`default_nettype none

module xr_mem_top import xr_pkg::*; (
    input  wire logic       clk,
    input  wire logic       rst_i,

    input  wire host_req_t  host_i,
    output      logic       host_ack_o,
    output      word_t      host_data_o,

    input  wire copp_req_t  copp_i,
    output      logic       copp_ack_o,

    input  wire logic       vid_color_sel_i,
    input  wire color_t     vid_color_a_addr_i,
    input  wire color_t     vid_color_b_addr_i,
    output      argb_t      vid_color_a_o,
    output      argb_t      vid_color_b_o,

    input  wire logic       vid_tile_sel_i,
    input  wire tile_addr_t vid_tile_addr_i,
    output      word_t      vid_tile_data_o,

    input  wire logic       copp_prog_sel_i,
    input  wire copp_addr_t copp_prog_addr_i,
    output      word_t      copp_prog_data_o
);

    // register bus between arbiter and register file
    xreg_bus_t xreg;
    word_t     xreg_data;

    xr_mem_arb u_xr_mem_arb (
        .clk                (clk),
        .rst_i              (rst_i),
        .host_i             (host_i),
        .host_ack_o         (host_ack_o),
        .host_data_o        (host_data_o),
        .copp_i             (copp_i),
        .copp_ack_o         (copp_ack_o),
        .xreg_o             (xreg),
        .xreg_data_i        (xreg_data),
        .vid_color_sel_i    (vid_color_sel_i),
        .vid_color_a_addr_i (vid_color_a_addr_i),
        .vid_color_b_addr_i (vid_color_b_addr_i),
        .vid_color_a_o      (vid_color_a_o),
        .vid_color_b_o      (vid_color_b_o),
        .vid_tile_sel_i     (vid_tile_sel_i),
        .vid_tile_addr_i    (vid_tile_addr_i),
        .vid_tile_data_o    (vid_tile_data_o),
        .copp_prog_sel_i    (copp_prog_sel_i),
        .copp_prog_addr_i   (copp_prog_addr_i),
        .copp_prog_data_o   (copp_prog_data_o)
    );

    xr_regs u_xr_regs (
        .clk         (clk),
        .rst_i       (rst_i),
        .xreg_i      (xreg),
        .xreg_data_o (xreg_data)
    );

endmodule

`default_nettype wire

//--- testbench/xr_mem_tb.sv
// Testbench for the XR memory block. Plays the host, the copper and the
// video generator against a model of the registers and the five RAMs,
// with fixed-seed random traffic. Compile it with list.f as the top.

`timescale 1ns/10ps

`include "xr_settings.svh"

module xr_mem_tb import xr_pkg::*; ();

    localparam int ACK_LIMIT   = 40;
    localparam int HOLD_CYCLES = 12;

    // one set of video read addresses, driven together each cycle
    typedef struct packed {
        color_t     color_a;
        color_t     color_b;
        tile_addr_t tile;
        copp_addr_t copp;
    } vid_addr_t;

    logic       clk;
    logic       rst_i;
    host_req_t  host;
    copp_req_t  copp;
    logic       host_ack;
    logic       copp_ack;
    word_t      host_data;
    logic       vid_color_sel;
    logic       vid_tile_sel;
    logic       copp_prog_sel;
    vid_addr_t  vid_addr;
    argb_t      vid_color_a;
    argb_t      vid_color_b;
    word_t      vid_tile_data;
    word_t      copp_prog_data;
    integer     seed;

    // reference model of the register file and the RAMs
    word_t regs_m  [0:`XR_NUM_REGS-1];
    word_t pal_a_m [0:(1 << `XR_COLOR_W)-1];
    word_t pal_b_m [0:(1 << `XR_COLOR_W)-1];
    word_t tile_m  [0:(1 << `XR_TILE_W)-1];
    word_t tile2_m [0:(1 << `XR_TILE2_W)-1];
    word_t copp_m  [0:(1 << `XR_COPP_W)-1];

    xr_mem_top u_xr_mem_top (
        .clk                (clk),
        .rst_i              (rst_i),
        .host_i             (host),
        .host_ack_o         (host_ack),
        .host_data_o        (host_data),
        .copp_i             (copp),
        .copp_ack_o         (copp_ack),
        .vid_color_sel_i    (vid_color_sel),
        .vid_color_a_addr_i (vid_addr.color_a),
        .vid_color_b_addr_i (vid_addr.color_b),
        .vid_color_a_o      (vid_color_a),
        .vid_color_b_o      (vid_color_b),
        .vid_tile_sel_i     (vid_tile_sel),
        .vid_tile_addr_i    (vid_addr.tile),
        .vid_tile_data_o    (vid_tile_data),
        .copp_prog_sel_i    (copp_prog_sel),
        .copp_prog_addr_i   (vid_addr.copp),
        .copp_prog_data_o   (copp_prog_data)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    task automatic stop_on_error();
        $display("Something failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_argb(input string name, input argb_t exp, input argb_t act);
        if (act !== exp) begin
            $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_ack(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("CHECK FAILED at %0t: %s expected %b, got %b", $time, name, exp, act);
            stop_on_error();
        end
    endtask

    // bank bit on top of the video tile address picks the second bank
    function automatic word_t tile_word(input tile_addr_t t);
        if (t[`XR_TILE_W]) begin
            return tile2_m[t[`XR_TILE2_W-1:0]];
        end
        return tile_m[t[`XR_TILE_W-1:0]];
    endfunction

    function automatic word_t model_read(input addr_t a);
        case (a[15:14])
            XR_REGION_REGS: begin
                if (a[6:0] == 7'd0) begin
                    return `XR_ID_VALUE;
                end
                return (a[6:0] < `XR_NUM_REGS) ? regs_m[a[6:0]] : '0;
            end
            XR_REGION_COLOR: begin
                return a[`XR_COLOR_W] ? pal_b_m[a[`XR_COLOR_W-1:0]]
                                      : pal_a_m[a[`XR_COLOR_W-1:0]];
            end
            XR_REGION_TILE:  return tile_word(a[`XR_TILE_W:0]);
            default:         return copp_m[a[`XR_COPP_W-1:0]];
        endcase
    endfunction

    function automatic void model_write(input addr_t a, input word_t d);
        case (a[15:14])
            XR_REGION_REGS: begin
                if (a[6:0] != 7'd0 && a[6:0] < `XR_NUM_REGS) begin
                    regs_m[a[6:0]] = d;
                end
            end
            XR_REGION_COLOR: begin
                if (a[`XR_COLOR_W]) begin
                    pal_b_m[a[`XR_COLOR_W-1:0]] = d;
                end else begin
                    pal_a_m[a[`XR_COLOR_W-1:0]] = d;
                end
            end
            XR_REGION_TILE: begin
                if (a[`XR_TILE_W]) begin
                    tile2_m[a[`XR_TILE2_W-1:0]] = d;
                end else begin
                    tile_m[a[`XR_TILE_W-1:0]] = d;
                end
            end
            default: copp_m[a[`XR_COPP_W-1:0]] = d;
        endcase
    endfunction

    // register region addresses stay below 16 so most hit real registers
    function automatic addr_t rand_addr();
        addr_t a;
        a = $random(seed);
        if (a[15:14] == XR_REGION_REGS) begin
            a[6:4] = 3'b000;
        end
        return a;
    endfunction

    function automatic vid_addr_t rand_video();
        logic [63:0] r;
        r = {$random(seed), $random(seed)};
        return r[$bits(vid_addr_t)-1:0];
    endfunction

    function automatic word_t fill_word(input addr_t a);
        return {a[7:0], a[15:8]} ^ 16'h3c5a;
    endfunction

    task automatic host_access(input logic wr, input addr_t a, input word_t d);
        int waited;
        waited = 0;
        @(posedge clk);
        host.sel  <= 1'b1;
        host.wr   <= wr;
        host.addr <= a;
        host.data <= d;
        do begin
            @(negedge clk);
            waited++;
            if (waited > ACK_LIMIT) begin
                $display("host ack never came for address %h", a);
                stop_on_error();
            end
        end while (!host_ack);
        if (wr) begin
            model_write(a, d);
        end else begin
            check_word("host_data_o", model_read(a), host_data);
        end
        @(posedge clk);
        host.sel <= 1'b0;
        // the request was still held in the ack cycle, so no second ack
        @(negedge clk);
        check_ack("host_ack_o", 1'b0, host_ack);
    endtask

    task automatic copp_write(input addr_t a, input word_t d);
        int waited;
        waited = 0;
        @(posedge clk);
        copp.sel  <= 1'b1;
        copp.addr <= a;
        copp.data <= d;
        do begin
            @(negedge clk);
            waited++;
            if (waited > ACK_LIMIT) begin
                $display("copper ack never came for address %h", a);
                stop_on_error();
            end
        end while (!copp_ack);
        model_write(a, d);
        @(posedge clk);
        copp.sel <= 1'b0;
        @(negedge clk);
        check_ack("copp_ack_o", 1'b0, copp_ack);
    endtask

    task automatic fill_region(input addr_t base, input int count);
        for (int i = 0; i < count; i++) begin
            copp_write(base + addr_t'(i), fill_word(base + addr_t'(i)));
        end
    endtask

    // copper and host raise their writes on the same edge
    task automatic race_writes(input addr_t ca, input word_t cd, input addr_t ha,
                               input word_t hd);
        int   waited;
        logic copp_seen;
        logic host_seen;
        waited    = 0;
        copp_seen = 1'b0;
        host_seen = 1'b0;
        @(posedge clk);
        copp.sel  <= 1'b1;
        copp.addr <= ca;
        copp.data <= cd;
        host.sel  <= 1'b1;
        host.wr   <= 1'b1;
        host.addr <= ha;
        host.data <= hd;
        while (!host_seen) begin
            @(negedge clk);
            waited++;
            if (waited > ACK_LIMIT) begin
                $display("%s ack never came while both ports requested",
                         copp_seen ? "host" : "copper");
                stop_on_error();
            end
            if (copp_ack) begin
                check_ack("host_ack_o", 1'b0, host_ack);
                copp_seen = 1'b1;
                model_write(ca, cd);
            end else if (host_ack) begin
                if (!copp_seen) begin
                    $display("host ack came before the copper ack");
                    stop_on_error();
                end
                host_seen = 1'b1;
                model_write(ha, hd);
            end
            @(posedge clk);
            if (copp_seen) begin
                copp.sel <= 1'b0;
            end
            if (host_seen) begin
                host.sel <= 1'b0;
            end
        end
    endtask

    // all video selects high while a host read of a RAM waits
    task automatic video_hold(input addr_t ha);
        vid_addr_t cur;
        vid_addr_t prev;
        int        waited;
        cur = rand_video();
        @(posedge clk);
        vid_color_sel <= 1'b1;
        vid_tile_sel  <= 1'b1;
        copp_prog_sel <= 1'b1;
        vid_addr      <= cur;
        host.sel      <= 1'b1;
        host.wr       <= 1'b0;
        host.addr     <= ha;
        for (int k = 0; k < HOLD_CYCLES; k++) begin
            @(posedge clk);
            prev = cur;
            cur  = rand_video();
            vid_addr <= cur;
            @(negedge clk);
            check_argb("vid_color_a_o", argb_t'(pal_a_m[prev.color_a]), vid_color_a);
            check_argb("vid_color_b_o", argb_t'(pal_b_m[prev.color_b]), vid_color_b);
            check_word("vid_tile_data_o", tile_word(prev.tile), vid_tile_data);
            check_word("copp_prog_data_o", copp_m[prev.copp], copp_prog_data);
            check_ack("host_ack_o", 1'b0, host_ack);
        end
        // only the select of the read's own RAM keeps holding it off
        @(posedge clk);
        vid_color_sel <= (ha[15:14] == XR_REGION_COLOR);
        vid_tile_sel  <= (ha[15:14] == XR_REGION_TILE);
        copp_prog_sel <= (ha[15:14] == XR_REGION_COPPER);
        for (int k = 0; k < 3; k++) begin
            @(negedge clk);
            check_ack("host_ack_o", 1'b0, host_ack);
        end
        @(posedge clk);
        vid_color_sel <= 1'b0;
        vid_tile_sel  <= 1'b0;
        copp_prog_sel <= 1'b0;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
            if (waited > ACK_LIMIT) begin
                $display("host read ack never came after the video selects dropped");
                stop_on_error();
            end
        end while (!host_ack);
        check_word("host_data_o", model_read(ha), host_data);
        @(posedge clk);
        host.sel <= 1'b0;
    endtask

    initial begin
        addr_t ca;
        addr_t ha;
        word_t cd;
        seed          = 76988;
        rst_i         = 1'b1;
        host          = '0;
        copp          = '0;
        vid_color_sel = 1'b0;
        vid_tile_sel  = 1'b0;
        copp_prog_sel = 1'b0;
        vid_addr      = '0;
        for (int r = 0; r < `XR_NUM_REGS; r++) begin
            regs_m[r] = '0;
        end
        repeat (5) @(posedge clk);
        rst_i <= 1'b0;

        // ID and cleared registers, then random register writes
        for (int r = 0; r < 2 * `XR_NUM_REGS; r++) begin
            host_access(1'b0, addr_t'(r), '0);
        end
        repeat (30) host_access(1'b1, addr_t'($random(seed)) & 16'h0007, $random(seed));
        for (int r = 0; r < 2 * `XR_NUM_REGS; r++) begin
            host_access(1'b0, addr_t'(r), '0);
        end

        // known contents in every RAM through the copper port
        fill_region(16'h8000, 1 << `XR_COLOR_W);
        fill_region(16'h8000 | (16'h1 << `XR_COLOR_W), 1 << `XR_COLOR_W);
        fill_region(16'h4000, 1 << `XR_TILE_W);
        fill_region(16'h4000 | (16'h1 << `XR_TILE_W), 1 << `XR_TILE2_W);
        fill_region(16'hc000, 1 << `XR_COPP_W);

        // mixed random traffic over all regions
        for (int i = 0; i < 600; i++) begin
            case ($random(seed) & 3)
                0:       host_access(1'b1, rand_addr(), $random(seed));
                1:       copp_write(rand_addr(), $random(seed));
                default: host_access(1'b0, rand_addr(), '0);
            endcase
        end

        // every other race hits one address, the host value must remain
        for (int i = 0; i < 40; i++) begin
            ca = rand_addr();
            cd = $random(seed);
            ha = (i % 2 == 0) ? ca : rand_addr();
            race_writes(ca, cd, ha, $random(seed));
            host_access(1'b0, ca, '0);
            host_access(1'b0, ha, '0);
        end

        // host reads of tile, color and copper memory under video load
        for (int i = 0; i < 9; i++) begin
            ha = rand_addr();
            ha[15:14] = 2'(i % 3 + 1);
            video_hold(ha);
        end

        $display("Everything OK");
        $finish;
    end

endmodule

//--- list.f
+incdir+design
design/xr_pkg.sv
design/xr_ram.sv
design/xr_regs.sv
design/xr_mem_arb.sv
design/xr_mem_top.sv
testbench/xr_mem_tb.sv

//--- Bender.yml
package:
  name: xr_mem

export_include_dirs:
  - design

sources:
  # RTL in compile order
  - include_dirs:
      - design
    files:
      - design/xr_pkg.sv
      - design/xr_ram.sv
      - design/xr_regs.sv
      - design/xr_mem_arb.sv
      - design/xr_mem_top.sv

  - target: simulation
    include_dirs:
      - design
    files:
      - testbench/xr_mem_tb.sv
